// ==== project.f ====
isa_pkg.sv
ctrl_pkg.sv
op_decoder.sv
cpu_sequencer.sv
ctrl_outputs.sv
nrisc_ctrl.sv
tb_clock.sv
nrisc_ctrl_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = nrisc_ctrl_tb
RTL_TOP    = nrisc_ctrl
FILELIST   = project.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== nrisc_ctrl_tb.sv ====
// NRISC control unit testbench with directed instruction tests against a timing reference model
`timescale 1ns/1ns

module nrisc_ctrl_tb;

  localparam int MAX_CYCLES = 3000;  // About 210 instructions at up to 4 cycles each with margin
  localparam int B_ST  = 7;          // Two status bits
  localparam int B_PC  = 6;
  localparam int B_STK = 4;          // Two stack op bits
  localparam int B_RW  = 3;
  localparam int B_DAE = 2;
  localparam int B_DW  = 1;
  localparam int B_DL  = 0;

  logic                clk;
  logic                rst;
  isa_pkg::instr_t     instr;
  isa_pkg::flags_t     flags;
  isa_pkg::alu_op_t    alu_op;
  logic                inc_dec_sel;
  isa_pkg::reg_addr_t  rd;
  isa_pkg::reg_addr_t  rf1;
  isa_pkg::reg_addr_t  rf2;
  logic                imm_sel;
  logic                load_sel;
  logic                reg_write;
  logic                data_addr_en;
  logic                data_write;
  logic                data_load;
  ctrl_pkg::stack_op_t stack_op;
  ctrl_pkg::pc_sel_t   pc_sel;
  logic                pc_en;
  ctrl_pkg::state_t    status;

  int          err_cnt   = 0;
  int          test_cnt  = 0;
  int          instr_cnt = 0;
  int          cycles;
  logic [31:0] seed = 32'h87a3_0846;

  // Reference model with expected status and strobes per offset and the held controls
  logic [8:0]         e_vec [1:2];
  int                 e_len;     // Offset of the pc_en pulse
  ctrl_pkg::pc_sel_t  e_sel;
  isa_pkg::alu_op_t   m_alu  = '0;
  logic               m_inc  = 1'b0;
  isa_pkg::reg_addr_t m_rd   = '0;
  isa_pkg::reg_addr_t m_rf1  = '0;
  isa_pkg::reg_addr_t m_rf2  = '0;
  logic               m_imm  = 1'b0;
  logic               m_load = 1'b0;

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) i_clock (.clk(clk), .rst(rst));

  nrisc_ctrl i_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    seed = xorshift(seed);
    return seed;
  endfunction

  // Expected behavior of one word under the given flags
  task automatic expect_from_word(input isa_pkg::instr_t w, input isa_pkg::flags_t f);
    ctrl_pkg::instr_class_t cls;
    isa_pkg::alu_op_t       alu;
    logic                   inc;
    logic                   taken;
    cls   = ctrl_pkg::CL_NOP;
    alu   = {1'b0, isa_pkg::ALU_ADD};  // Address and target math
    inc   = 1'b0;
    taken = 1'b1;
    case (w[15:12])
      isa_pkg::OP_SYS: begin
        case (w[11:8])
          isa_pkg::SYS_CALL: cls = ctrl_pkg::CL_CALL;
          isa_pkg::SYS_RET:  cls = ctrl_pkg::CL_RET;
          isa_pkg::SYS_RETI: cls = ctrl_pkg::CL_RETI;
          default:           cls = ctrl_pkg::CL_NOP;
        endcase
      end
      isa_pkg::OP_LW:  cls = ctrl_pkg::CL_LOAD;
      isa_pkg::OP_SW:  cls = ctrl_pkg::CL_STORE;
      isa_pkg::OP_LI:  cls = ctrl_pkg::CL_LOAD_IMM;
      isa_pkg::OP_JMP: cls = ctrl_pkg::CL_JUMP;
      isa_pkg::OP_JZ: begin
        cls   = ctrl_pkg::CL_JUMP;
        taken = f[isa_pkg::FLAG_ZERO];
      end
      isa_pkg::OP_JC: begin
        cls   = ctrl_pkg::CL_JUMP;
        taken = f[isa_pkg::FLAG_CARRY];
      end
      isa_pkg::OP_JM: begin
        cls   = ctrl_pkg::CL_JUMP;
        taken = f[isa_pkg::FLAG_MINUS];
      end
      isa_pkg::OP_UNARY: begin
        cls = ctrl_pkg::CL_ALU;
        case (w[3:0])
          isa_pkg::UN_NOT: alu[2:0] = isa_pkg::ALU_NOT;
          isa_pkg::UN_INC: inc = 1'b1;  // rd + 1
          isa_pkg::UN_DEC: begin
            alu[2:0] = isa_pkg::ALU_SUB;
            inc      = 1'b1;
          end
          default: cls = ctrl_pkg::CL_NOP;
        endcase
      end
      default: begin                    // ADD through SHL
        cls = ctrl_pkg::CL_ALU;
        case (w[15:12])
          isa_pkg::OP_SUB: alu[2:0] = isa_pkg::ALU_SUB;
          isa_pkg::OP_AND: alu[2:0] = isa_pkg::ALU_AND;
          isa_pkg::OP_OR:  alu[2:0] = isa_pkg::ALU_OR;
          isa_pkg::OP_XOR: alu[2:0] = isa_pkg::ALU_XOR;
          isa_pkg::OP_SHR: alu = {w[0], isa_pkg::ALU_SHR};  // Rotate from bit 0
          isa_pkg::OP_SHL: alu = {w[0], isa_pkg::ALU_SHL};
          default:         alu[2:0] = isa_pkg::ALU_ADD;
        endcase
      end
    endcase

    e_vec[1] = '0;
    e_vec[2] = '0;
    e_len    = 2;
    e_sel    = ctrl_pkg::PC_INC;
    case (cls)
      ctrl_pkg::CL_LOAD, ctrl_pkg::CL_STORE: begin
        e_vec[1][B_ST +: 2] = ctrl_pkg::ST_MEM;
        e_vec[1][B_DAE]     = 1'b1;
        e_vec[2][B_DL]      = (cls == ctrl_pkg::CL_LOAD);
        e_vec[2][B_RW]      = (cls == ctrl_pkg::CL_LOAD);
        e_vec[2][B_DW]      = (cls == ctrl_pkg::CL_STORE);
      end
      ctrl_pkg::CL_CALL: begin
        e_vec[1][B_ST +: 2]  = ctrl_pkg::ST_JUMP;
        e_vec[1][B_STK +: 2] = ctrl_pkg::STK_PUSH;  // Return address saved first
        e_sel                = ctrl_pkg::PC_ALU;
      end
      ctrl_pkg::CL_RET, ctrl_pkg::CL_RETI: begin
        e_vec[1][B_ST +: 2]  = ctrl_pkg::ST_RETURN;
        e_vec[1][B_STK +: 2] = ctrl_pkg::STK_POP;
        e_sel                = ctrl_pkg::PC_STACK;
      end
      default: begin
        if (cls == ctrl_pkg::CL_JUMP && taken) begin
          e_vec[1][B_ST +: 2] = ctrl_pkg::ST_JUMP;
          e_sel               = ctrl_pkg::PC_ALU;
        end else begin                 // Single cycle where the PC steps
          e_len          = 1;
          e_vec[1][B_RW] = (cls == ctrl_pkg::CL_ALU) || (cls == ctrl_pkg::CL_LOAD_IMM);
        end
      end
    endcase
    e_vec[e_len][B_PC] = 1'b1;

    // A no-op leaves the held controls alone
    if (cls != ctrl_pkg::CL_NOP) begin
      m_rd   = w[11:8];
      m_imm  = (cls == ctrl_pkg::CL_LOAD_IMM);
      m_load = (cls == ctrl_pkg::CL_LOAD);
      if (cls != ctrl_pkg::CL_LOAD_IMM) begin  // LI keeps the ALU setup
        m_alu = alu;
        m_inc = inc;
        m_rf1 = w[7:4];
        m_rf2 = w[3:0];
      end
    end
    if (cls == ctrl_pkg::CL_STORE) begin      // Store data as rd AND rd
      m_alu = {1'b0, isa_pkg::ALU_AND};
      m_rf1 = w[11:8];
      m_rf2 = w[11:8];
    end
  endtask

  // Presents one word and records status and strobes per offset until pc_en
  task automatic drive_and_check(input isa_pkg::instr_t w, input isa_pkg::flags_t f);
    logic [8:0] got [1:4];
    int         n;
    int         k;
    expect_from_word(w, f);
    @(posedge clk);
    instr <= w;
    flags <= f;
    @(posedge clk);  // Decode edge
    n = 0;
    do begin
      @(negedge clk);
      n++;
      got[n] = {status, pc_en, stack_op, reg_write, data_addr_en, data_write, data_load};
    end while (!pc_en && n < 4);
    instr_cnt++;
    if (!pc_en) begin
      $display("Error at %0t: word %h gave no PC update within 4 cycles", $time, w);
      err_cnt++;
    end else if (n != e_len) begin
      $display("Mismatch at %0t: word %h pc_en at offset %0d, expected %0d",
               $time, w, n, e_len);
      err_cnt++;
    end else begin
      for (k = 1; k <= n; k++) begin
        if (got[k] !== e_vec[k]) begin
          $display("Mismatch at %0t: word %h offset %0d status/strobes %b, expected %b",
                   $time, w, k, got[k], e_vec[k]);
          err_cnt++;
        end
      end
      if (pc_sel !== e_sel) begin
        $display("Mismatch at %0t: word %h pc_sel %0d, expected %0d", $time, w, pc_sel, e_sel);
        err_cnt++;
      end
      if ({alu_op, inc_dec_sel, rd, rf1, rf2, imm_sel, load_sel} !==
          {m_alu, m_inc, m_rd, m_rf1, m_rf2, m_imm, m_load}) begin
        $display("Mismatch at %0t: word %h ctrl %h/%b/%h%h%h/%b%b, expected %h/%b/%h%h%h/%b%b",
                 $time, w, alu_op, inc_dec_sel, rd, rf1, rf2, imm_sel, load_sel,
                 m_alu, m_inc, m_rd, m_rf1, m_rf2, m_imm, m_load);
        err_cnt++;
      end
    end
  endtask

  task automatic report_test(input string name, input int start);
    test_cnt++;
    $display("%0t: %s finished with %0d errors", $time, name, err_cnt - start);
  endtask

  task automatic reset_values();
    logic [29:0] outs;
    int          start;
    int          n;
    start = err_cnt;
    do begin
      @(negedge clk);
    end while (rst);
    outs = {pc_en, reg_write, data_addr_en, data_write, data_load, stack_op, pc_sel, status,
            alu_op, inc_dec_sel, rd, rf1, rf2, imm_sel, load_sel};
    if (outs !== '0) begin
      $display("Mismatch at %0t: outputs after reset %h, expected all zero", $time, outs);
      err_cnt++;
    end
    n = 0;
    while (!pc_en && n < 4) begin   // Idle word is a no-op whose PC step is waited out
      @(negedge clk);
      n++;
    end
    if (!pc_en) begin
      $display("Error at %0t: no PC update after reset was released", $time);
      err_cnt++;
    end
    report_test("reset", start);
  endtask

  task automatic alu_instructions();
    isa_pkg::sub_op_t un_codes [3];
    logic [31:0]      r;
    int               start;
    int               i;
    start    = err_cnt;
    un_codes = '{isa_pkg::UN_NOT, isa_pkg::UN_INC, isa_pkg::UN_DEC};
    for (i = 0; i < 80; i++) begin
      r = next_random();
      if (i % 10 < 7) begin
        drive_and_check({isa_pkg::OP_ADD + 4'(i % 10), r[11:0]}, r[18:16]);
      end else begin
        drive_and_check({isa_pkg::OP_UNARY, r[11:4], un_codes[i % 10 - 7]}, r[18:16]);
      end
    end
    report_test("alu", start);
  endtask

  task automatic memory_access();
    isa_pkg::opcode_t ops [3];
    logic [31:0]      r;
    int               start;
    int               i;
    start = err_cnt;
    ops   = '{isa_pkg::OP_LI, isa_pkg::OP_LW, isa_pkg::OP_SW};
    for (i = 0; i < 30; i++) begin
      r = next_random();
      drive_and_check({ops[i % 3], r[11:0]}, r[18:16]);
    end
    report_test("memory", start);
  endtask

  task automatic conditional_jumps();
    logic [31:0] r;
    int          start;
    int          i;
    start = err_cnt;
    for (i = 0; i < 40; i++) begin
      r = next_random();
      drive_and_check({isa_pkg::OP_JMP + 4'(i % 4), r[11:0]}, r[18:16]);  // JMP, JZ, JC, JM
    end
    report_test("jumps", start);
  endtask

  task automatic call_and_return();
    isa_pkg::sub_op_t subs [3];
    logic [31:0]      r;
    int               start;
    int               i;
    start = err_cnt;
    subs  = '{isa_pkg::SYS_CALL, isa_pkg::SYS_RET, isa_pkg::SYS_RETI};
    for (i = 0; i < 30; i++) begin
      r = next_random();
      drive_and_check({isa_pkg::OP_SYS, subs[i % 3], r[7:0]}, r[18:16]);
    end
    report_test("subroutines", start);
  endtask

  // System codes other than CALL/RET/RETI and unary codes other than NOT/INC/DEC
  task automatic dropped_opcodes();
    logic [31:0] r;
    int          start;
    int          i;
    start = err_cnt;
    for (i = 0; i < 16; i++) begin
      r = next_random();
      if (4'(i) != isa_pkg::SYS_CALL && 4'(i) != isa_pkg::SYS_RET &&
          4'(i) != isa_pkg::SYS_RETI) begin
        drive_and_check({isa_pkg::OP_SYS, 4'(i), r[7:0]}, r[18:16]);
      end
      if (4'(i) != isa_pkg::UN_NOT && 4'(i) != isa_pkg::UN_INC &&
          4'(i) != isa_pkg::UN_DEC) begin
        drive_and_check({isa_pkg::OP_UNARY, r[11:4], 4'(i)}, r[18:16]);
      end
    end
    report_test("dropped", start);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    instr = '0;  // HALT runs as a no-op
    flags = '0;
    reset_values();
    alu_instructions();
    memory_access();
    conditional_jumps();
    call_and_return();
    dropped_opcodes();
    $display("%0d tests, %0d instructions, %0d errors", test_cnt, instr_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset spans a fixed number of rising edges
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;  // Released on a rising edge
  end

endmodule

// ==== nrisc_ctrl.sv ====
// NRISC control unit top: decoder, sequencer and output register stage
`timescale 1ns/1ns

module nrisc_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  isa_pkg::instr_t      instr,
  input  isa_pkg::flags_t      flags,
  output isa_pkg::alu_op_t     alu_op,
  output logic                 inc_dec_sel,
  output isa_pkg::reg_addr_t   rd,
  output isa_pkg::reg_addr_t   rf1,
  output isa_pkg::reg_addr_t   rf2,
  output logic                 imm_sel,
  output logic                 load_sel,
  output logic                 reg_write,
  output logic                 data_addr_en,
  output logic                 data_write,
  output logic                 data_load,
  output ctrl_pkg::stack_op_t  stack_op,
  output ctrl_pkg::pc_sel_t    pc_sel,
  output logic                 pc_en,
  output ctrl_pkg::state_t     status
);

  ctrl_pkg::instr_class_t iclass;
  ctrl_pkg::cond_t        cond;
  isa_pkg::alu_op_t       dec_alu_op;   // Unregistered decode results
  logic                   dec_inc_dec;
  isa_pkg::reg_addr_t     dec_rd;
  isa_pkg::reg_addr_t     dec_rf1;
  isa_pkg::reg_addr_t     dec_rf2;
  ctrl_pkg::state_t       state;

  assign status = state;

  op_decoder i_decoder (
    .instr       (instr),
    .iclass      (iclass),
    .cond        (cond),
    .alu_op      (dec_alu_op),
    .inc_dec_sel (dec_inc_dec),
    .rd          (dec_rd),
    .rf1         (dec_rf1),
    .rf2         (dec_rf2)
  );

  cpu_sequencer i_sequencer (
    .clk      (clk),
    .rst      (rst),
    .iclass   (iclass),
    .cond     (cond),
    .flags    (flags),
    .state    (state),
    .pc_en    (pc_en),
    .pc_sel   (pc_sel),
    .stack_op (stack_op)
  );

  ctrl_outputs i_outputs (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .iclass       (iclass),
    .alu_op_in    (dec_alu_op),
    .inc_dec_in   (dec_inc_dec),
    .rd_in        (dec_rd),
    .rf1_in       (dec_rf1),
    .rf2_in       (dec_rf2),
    .alu_op       (alu_op),
    .inc_dec_sel  (inc_dec_sel),
    .rd           (rd),
    .rf1          (rf1),
    .rf2          (rf2),
    .imm_sel      (imm_sel),
    .load_sel     (load_sel),
    .reg_write    (reg_write),
    .data_addr_en (data_addr_en),
    .data_write   (data_write),
    .data_load    (data_load)
  );

endmodule

// ==== ctrl_outputs.sv ====
// Datapath control register stage with register-write and data-memory strobes
`timescale 1ns/1ns

module ctrl_outputs (
  input  logic                    clk,
  input  logic                    rst,
  input  ctrl_pkg::state_t        state,
  input  ctrl_pkg::instr_class_t  iclass,
  input  isa_pkg::alu_op_t        alu_op_in,
  input  logic                    inc_dec_in,
  input  isa_pkg::reg_addr_t      rd_in,
  input  isa_pkg::reg_addr_t      rf1_in,
  input  isa_pkg::reg_addr_t      rf2_in,
  output isa_pkg::alu_op_t        alu_op,
  output logic                    inc_dec_sel,
  output isa_pkg::reg_addr_t      rd,
  output isa_pkg::reg_addr_t      rf1,
  output isa_pkg::reg_addr_t      rf2,
  output logic                    imm_sel,
  output logic                    load_sel,
  output logic                    reg_write,
  output logic                    data_addr_en,
  output logic                    data_write,
  output logic                    data_load
);

  logic skip_decode;  // High in the PC update cycle of each instruction
  logic decode_edge;
  logic is_load;
  logic is_store;
  logic writes_reg;   // ALU result or immediate goes to rd

  assign decode_edge = (state == ctrl_pkg::ST_DECODE) && !skip_decode;
  assign is_load     = (iclass == ctrl_pkg::CL_LOAD);
  assign is_store    = (iclass == ctrl_pkg::CL_STORE);
  assign writes_reg  = (iclass == ctrl_pkg::CL_ALU) || (iclass == ctrl_pkg::CL_LOAD_IMM);

  // Tracks the sequencer's pc_en cycle so the same word never decodes twice
  always_ff @(posedge clk) begin
    if (rst) begin
      skip_decode <= 1'b0;
    end else if (state != ctrl_pkg::ST_DECODE) begin
      skip_decode <= 1'b1;           // Return to decode lands on the PC update
    end else begin
      skip_decode <= !skip_decode;   // Decode edge followed by one idle edge
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_op       <= '0;
      inc_dec_sel  <= 1'b0;
      rd           <= '0;
      rf1          <= '0;
      rf2          <= '0;
      imm_sel      <= 1'b0;
      load_sel     <= 1'b0;
      reg_write    <= 1'b0;
      data_addr_en <= 1'b0;
      data_write   <= 1'b0;
      data_load    <= 1'b0;
    end else begin
      reg_write    <= 1'b0;
      data_addr_en <= 1'b0;
      data_write   <= 1'b0;
      data_load    <= 1'b0;

      if (decode_edge && iclass != ctrl_pkg::CL_NOP) begin
        imm_sel  <= (iclass == ctrl_pkg::CL_LOAD_IMM);  // Immediate to register input
        load_sel <= is_load;                            // Memory data to register input
        rd       <= rd_in;
        if (iclass != ctrl_pkg::CL_LOAD_IMM) begin      // LI leaves the ALU alone
          alu_op      <= alu_op_in;
          inc_dec_sel <= inc_dec_in;
          rf1         <= rf1_in;
          rf2         <= rf2_in;
        end
        reg_write    <= writes_reg;
        data_addr_en <= is_load || is_store;  // Latch rf1 + rf2 as address
      end

      if (state == ctrl_pkg::ST_MEM) begin
        if (is_load) begin
          data_load <= 1'b1;
          reg_write <= 1'b1;     // Loaded word into rd
        end
        if (is_store) begin
          // rd AND rd passes the store data through the ALU
          rf1        <= rd_in;
          rf2        <= rd_in;
          alu_op     <= {1'b0, isa_pkg::ALU_AND};
          data_write <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== cpu_sequencer.sv ====
// Instruction sequencer: state machine, branch test, PC update and stack pulses
`timescale 1ns/1ns

module cpu_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  ctrl_pkg::instr_class_t  iclass,
  input  ctrl_pkg::cond_t         cond,
  input  isa_pkg::flags_t         flags,
  output ctrl_pkg::state_t        state,
  output logic                    pc_en,
  output ctrl_pkg::pc_sel_t       pc_sel,
  output ctrl_pkg::stack_op_t     stack_op
);

  logic cond_met;   // Jump taken
  logic decode_ok;  // Decode edge; skipped while the PC update is out

  always_comb begin
    case (cond)
      ctrl_pkg::COND_ZERO:  cond_met = flags[isa_pkg::FLAG_ZERO];
      ctrl_pkg::COND_CARRY: cond_met = flags[isa_pkg::FLAG_CARRY];
      ctrl_pkg::COND_MINUS: cond_met = flags[isa_pkg::FLAG_MINUS];
      default:              cond_met = 1'b1;  // JMP
    endcase
  end

  // Held word is still present during the pc_en cycle
  assign decode_ok = (state == ctrl_pkg::ST_DECODE) && !pc_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ctrl_pkg::ST_DECODE;
      pc_en    <= 1'b0;
      pc_sel   <= ctrl_pkg::PC_INC;
      stack_op <= ctrl_pkg::STK_NONE;
    end else begin
      pc_en    <= 1'b0;               // Strobes last one cycle
      stack_op <= ctrl_pkg::STK_NONE;

      case (state)
        ctrl_pkg::ST_DECODE: begin
          if (decode_ok) begin
            case (iclass)
              ctrl_pkg::CL_LOAD,
              ctrl_pkg::CL_STORE: state <= ctrl_pkg::ST_MEM;  // PC steps after access
              ctrl_pkg::CL_JUMP: begin
                if (cond_met) begin
                  state <= ctrl_pkg::ST_JUMP;
                end else begin
                  pc_en  <= 1'b1;      // Not taken, fall through
                  pc_sel <= ctrl_pkg::PC_INC;
                end
              end
              ctrl_pkg::CL_CALL: begin
                stack_op <= ctrl_pkg::STK_PUSH;  // Save return address
                state    <= ctrl_pkg::ST_JUMP;
              end
              ctrl_pkg::CL_RET,
              ctrl_pkg::CL_RETI: begin
                stack_op <= ctrl_pkg::STK_POP;
                state    <= ctrl_pkg::ST_RETURN;
              end
              default: begin                    // ALU, LI, no-op
                pc_en  <= 1'b1;
                pc_sel <= ctrl_pkg::PC_INC;
              end
            endcase
          end
        end
        ctrl_pkg::ST_MEM: begin
          pc_en  <= 1'b1;
          pc_sel <= ctrl_pkg::PC_INC;
          state  <= ctrl_pkg::ST_DECODE;
        end
        ctrl_pkg::ST_JUMP: begin
          pc_en  <= 1'b1;
          pc_sel <= ctrl_pkg::PC_ALU;   // Target from rf1 + rf2
          state  <= ctrl_pkg::ST_DECODE;
        end
        default: begin                   // ST_RETURN
          pc_en  <= 1'b1;
          pc_sel <= ctrl_pkg::PC_STACK;
          state  <= ctrl_pkg::ST_DECODE;
        end
      endcase
    end
  end

endmodule

// ==== op_decoder.sv ====
// Instruction decoder that classifies the word and builds ALU setup and register fields
`timescale 1ns/1ns

module op_decoder (
  input  isa_pkg::instr_t         instr,
  output ctrl_pkg::instr_class_t  iclass,
  output ctrl_pkg::cond_t         cond,
  output isa_pkg::alu_op_t        alu_op,
  output logic                    inc_dec_sel,
  output isa_pkg::reg_addr_t      rd,
  output isa_pkg::reg_addr_t      rf1,
  output isa_pkg::reg_addr_t      rf2
);

  isa_pkg::opcode_t opcode;
  isa_pkg::sub_op_t sys_sub;   // Shares the rd field
  isa_pkg::sub_op_t un_sub;    // Shares the rf2 field
  logic             rot;       // Rotate instead of shift

  assign opcode = instr[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
  assign rd     = instr[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W];
  assign rf1    = instr[isa_pkg::RF1_LSB +: isa_pkg::REG_ADDR_W];
  assign rf2    = instr[isa_pkg::RF2_LSB +: isa_pkg::REG_ADDR_W];

  assign sys_sub = rd;
  assign un_sub  = rf2;
  assign rot     = instr[isa_pkg::ROT_BIT];

  always_comb begin
    // Default no-op with the ALU adding for address and target math
    iclass      = ctrl_pkg::CL_NOP;
    cond        = ctrl_pkg::COND_ALWAYS;
    alu_op      = {1'b0, isa_pkg::ALU_ADD};
    inc_dec_sel = 1'b0;

    case (opcode)
      isa_pkg::OP_SYS: begin
        case (sys_sub)
          isa_pkg::SYS_CALL: iclass = ctrl_pkg::CL_CALL;  // Target = rf1 + rf2
          isa_pkg::SYS_RET:  iclass = ctrl_pkg::CL_RET;
          isa_pkg::SYS_RETI: iclass = ctrl_pkg::CL_RETI;
          default:           iclass = ctrl_pkg::CL_NOP;   // HALT, WAIT, SLEEP and the rest
        endcase
      end

      // Memory address is rf1 + rf2
      isa_pkg::OP_LW: iclass = ctrl_pkg::CL_LOAD;
      isa_pkg::OP_SW: iclass = ctrl_pkg::CL_STORE;
      isa_pkg::OP_LI: iclass = ctrl_pkg::CL_LOAD_IMM;

      // Jump target is rf1 + rf2
      isa_pkg::OP_JMP: iclass = ctrl_pkg::CL_JUMP;
      isa_pkg::OP_JZ: begin
        iclass = ctrl_pkg::CL_JUMP;
        cond   = ctrl_pkg::COND_ZERO;
      end
      isa_pkg::OP_JC: begin
        iclass = ctrl_pkg::CL_JUMP;
        cond   = ctrl_pkg::COND_CARRY;
      end
      isa_pkg::OP_JM: begin
        iclass = ctrl_pkg::CL_JUMP;
        cond   = ctrl_pkg::COND_MINUS;
      end

      // Two-operand ALU group
      isa_pkg::OP_ADD: iclass = ctrl_pkg::CL_ALU;
      isa_pkg::OP_SUB: begin
        iclass = ctrl_pkg::CL_ALU;
        alu_op = {1'b0, isa_pkg::ALU_SUB};
      end
      isa_pkg::OP_AND: begin
        iclass = ctrl_pkg::CL_ALU;
        alu_op = {1'b0, isa_pkg::ALU_AND};
      end
      isa_pkg::OP_OR: begin
        iclass = ctrl_pkg::CL_ALU;
        alu_op = {1'b0, isa_pkg::ALU_OR};
      end
      isa_pkg::OP_XOR: begin
        iclass = ctrl_pkg::CL_ALU;
        alu_op = {1'b0, isa_pkg::ALU_XOR};
      end
      isa_pkg::OP_SHR: begin
        iclass = ctrl_pkg::CL_ALU;
        alu_op = {rot, isa_pkg::ALU_SHR};  // RTR when bit 0 set
      end
      isa_pkg::OP_SHL: begin
        iclass = ctrl_pkg::CL_ALU;
        alu_op = {rot, isa_pkg::ALU_SHL};  // RTL when bit 0 set
      end

      isa_pkg::OP_UNARY: begin
        case (un_sub)
          isa_pkg::UN_NOT: begin
            iclass = ctrl_pkg::CL_ALU;
            alu_op = {1'b0, isa_pkg::ALU_NOT};
          end
          isa_pkg::UN_INC: begin
            iclass      = ctrl_pkg::CL_ALU;
            inc_dec_sel = 1'b1;                 // Second operand forced to 1
          end
          isa_pkg::UN_DEC: begin
            iclass      = ctrl_pkg::CL_ALU;
            alu_op      = {1'b0, isa_pkg::ALU_SUB};
            inc_dec_sel = 1'b1;
          end
          default: iclass = ctrl_pkg::CL_NOP;    // TWC and unused codes
        endcase
      end
    endcase
  end

endmodule

// ==== ctrl_pkg.sv ====
// Control unit types: sequencer state, instruction class, branch condition, PC and stack ops
package ctrl_pkg;

  // Sequencer state, also visible on the status output
  typedef enum logic [1:0] {
    ST_DECODE = 2'd0,  // Waiting for or decoding an instruction
    ST_MEM    = 2'd1,  // Data memory access of LW or SW
    ST_JUMP   = 2'd2,  // PC load from ALU result
    ST_RETURN = 2'd3   // PC load from stack top
  } state_t;

  // What the decoder found in the instruction word
  typedef enum logic [3:0] {
    CL_NOP,       // Dropped or unknown, PC steps only
    CL_ALU,       // Register to register ALU op
    CL_LOAD,      // LW
    CL_STORE,     // SW
    CL_LOAD_IMM,  // LI
    CL_JUMP,      // JMP and conditional jumps
    CL_CALL,
    CL_RET,
    CL_RETI
  } instr_class_t;

  // Flag tested by a jump
  typedef enum logic [1:0] {
    COND_ALWAYS,
    COND_ZERO,
    COND_CARRY,
    COND_MINUS
  } cond_t;

  // Program counter source mux
  typedef enum logic [1:0] {
    PC_INC   = 2'd0,  // PC + 1
    PC_ALU   = 2'd1,  // Jump target from ALU
    PC_STACK = 2'd2   // Return address
  } pc_sel_t;

  typedef enum logic [1:0] {
    STK_NONE = 2'd0,
    STK_PUSH = 2'd1,
    STK_POP  = 2'd2
  } stack_op_t;

endpackage

// ==== isa_pkg.sv ====
// NRISC instruction set: word layout, opcodes, ALU operation codes and flag bits
package isa_pkg;

  localparam int INSTR_W    = 16;
  localparam int OPCODE_W   = 4;
  localparam int REG_ADDR_W = 4;

  typedef logic [INSTR_W-1:0]    instr_t;     // Full instruction word
  typedef logic [OPCODE_W-1:0]   opcode_t;    // Major opcode
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register file address
  typedef logic [3:0]            sub_op_t;    // System or unary sub-opcode

  // Field positions in the instruction word
  localparam int OPCODE_LSB = 12;  // Bits 15:12
  localparam int RD_LSB     = 8;   // Bits 11:8, also system sub-opcode
  localparam int RF1_LSB    = 4;   // Bits 7:4
  localparam int RF2_LSB    = 0;   // Bits 3:0, also unary sub-opcode
  localparam int ROT_BIT    = 0;   // Rotate select for shifts

  // Major opcodes
  localparam opcode_t OP_SYS   = 4'h0;
  localparam opcode_t OP_LW    = 4'h1;
  localparam opcode_t OP_SW    = 4'h2;
  localparam opcode_t OP_LI    = 4'h3;
  localparam opcode_t OP_JMP   = 4'h4;
  localparam opcode_t OP_JZ    = 4'h5;
  localparam opcode_t OP_JC    = 4'h6;
  localparam opcode_t OP_JM    = 4'h7;
  localparam opcode_t OP_ADD   = 4'h8;
  localparam opcode_t OP_SUB   = 4'h9;
  localparam opcode_t OP_AND   = 4'hA;
  localparam opcode_t OP_OR    = 4'hB;
  localparam opcode_t OP_XOR   = 4'hC;
  localparam opcode_t OP_SHR   = 4'hD;  // SHR or RTR
  localparam opcode_t OP_SHL   = 4'hE;  // SHL or RTL
  localparam opcode_t OP_UNARY = 4'hF;  // NOT, INC, DEC

  // System group, selected by bits 11:8
  localparam sub_op_t SYS_CALL = 4'h4;
  localparam sub_op_t SYS_RET  = 4'h5;
  localparam sub_op_t SYS_RETI = 4'h6;

  // Unary group, selected by bits 3:0
  localparam sub_op_t UN_NOT = 4'h0;
  localparam sub_op_t UN_INC = 4'h2;
  localparam sub_op_t UN_DEC = 4'h3;

  // ALU control: bit 3 rotate, bits 2:0 function
  typedef logic [3:0] alu_op_t;
  typedef logic [2:0] alu_fn_t;

  localparam alu_fn_t ALU_ADD = 3'd0;
  localparam alu_fn_t ALU_SUB = 3'd1;
  localparam alu_fn_t ALU_AND = 3'd2;
  localparam alu_fn_t ALU_OR  = 3'd3;
  localparam alu_fn_t ALU_XOR = 3'd4;
  localparam alu_fn_t ALU_SHR = 3'd5;
  localparam alu_fn_t ALU_SHL = 3'd6;
  localparam alu_fn_t ALU_NOT = 3'd7;

  // ALU status flags
  typedef logic [2:0] flags_t;
  localparam int FLAG_MINUS = 0;
  localparam int FLAG_ZERO  = 1;
  localparam int FLAG_CARRY = 2;

endpackage
